//--- esmKs10.f
verilog/ks10Pkg.sv
verilog/conBusIf.sv
verilog/consoleBus.sv
verilog/dzMux.sv
verilog/sdSpi.sv
verilog/ks10Io.sv
verilog/esmKs10.sv
+incdir+verif
verif/tbEsmKs10.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, pass only when the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module tbEsmKs10 -f esmKs10.f -o simEsmKs10 &&
./obj_dir/simEsmKs10 | tee /dev/stderr | grep -q "^TEST OK$" &&
echo "Simulation passed" && exit 0 ||
{ echo "Simulation failed"; exit 1; }

//--- verif/tbUtil.svh
// Testbench helpers for the ESM KS10 board that the testbench top module includes

////////////////////////////////////////
// Random data
////////////////////////////////////////

// Fibonacci LFSR with taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
   return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [15:0] randBits(input int n);
   logic [15:0] v;
   v = '0;
   for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);   // One step per bit
      v = {v[14:0], lfsrState[0]};
   end
   return v;
endfunction

////////////////////////////////////////
// Reference model
////////////////////////////////////////

// Enabled lanes take new data, others keep the old byte
function automatic conWordT laneMerge(input conWordT old, input conWordT data,
                                      input logic [1:0] lanes);
   conWordT r;
   r = old;
   if (lanes[0])
      r[7:0] = data[7:0];
   if (lanes[1])
      r[15:8] = data[15:8];
   return r;
endfunction

// DzRx layout with valid in 15 and line in 10:8
function automatic conWordT dzRxWord(input logic [2:0] line, input logic [7:0] ch);
   return {1'b1, 4'b0000, line, ch};
endfunction

// Active low interrupt pin
function automatic logic intrLevel(input logic rxAny, input logic spiFlag,
                                   input conWordT mask);
   return !((rxAny && mask[0]) || (spiFlag && mask[1]));
endfunction

////////////////////////////////////////
// Compare tasks
////////////////////////////////////////

task automatic checkWord(input string name, input conWordT got, input conWordT exp);
   checkCount++;
   if (got !== exp) begin
      $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
      errCount++;
   end
endtask

task automatic checkBit(input string name, input logic got, input logic exp);
   checkCount++;
   if (got !== exp) begin
      $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
      errCount++;
   end
endtask

task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
   checkCount++;
   if (got !== exp) begin
      $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
      errCount++;
   end
endtask

////////////////////////////////////////
// Console bus model
////////////////////////////////////////

task automatic conWrite(input regAddrT addr, input conWordT data, input logic [1:0] lanes);
   @(negedge clk);
   conAddr = addr;
   conDrv  = data;
   conOe   = 1'b1;
   conBleN = !lanes[0];
   conBheN = !lanes[1];
   conWrN  = 1'b0;
   repeat (StbClks) @(negedge clk);   // Strobe low time
   conWrN  = 1'b1;
   conOe   = 1'b0;
   conBleN = 1'b1;
   conBheN = 1'b1;
   repeat (StbClks) @(negedge clk);   // Gap to next access
endtask

task automatic conRead(input regAddrT addr, output conWordT data);
   @(negedge clk);
   conAddr = addr;
   conBleN = 1'b0;
   conBheN = 1'b0;
   conRdN  = 1'b0;
   repeat (StbClks) @(negedge clk);
   data    = conData;   // Driven since 2 clocks after strobe
   conRdN  = 1'b1;
   conBleN = 1'b1;
   conBheN = 1'b1;
   repeat (StbClks) @(negedge clk);   // Pop happens in here
endtask

// Poll until masked bits match or the poll limit runs out
task automatic waitReg(input regAddrT addr, input conWordT mask, input conWordT value,
                       input string what, output conWordT rd);
   int polls;
   polls = 0;
   conRead(addr, rd);
   while ((rd & mask) !== value && polls < MaxPolls) begin
      conRead(addr, rd);
      polls++;
   end
   if ((rd & mask) !== value) begin
      $display("%s after %0d register polls", what, polls);
      errCount++;
   end
endtask

task automatic applyReset();
   rstN = 1'b0;
   repeat (4) @(negedge clk);
   rstN = 1'b1;
   @(negedge clk);
endtask

task automatic endTest(input string name);
   testCount++;
   $display("Test %0d %-36s %0d errors", testCount, name, errCount - testErrBase);
   testErrBase = errCount;
endtask

//--- verif/tbEsmKs10.sv
// Testbench top for the ESM KS10 board, drives console bus, TTY and SD pins and checks results
`timescale 1ns/10ps

module tbEsmKs10 import ks10Pkg::*; ();

   localparam int NumTty     = 2;
   localparam int ClksPerBit = 16;
   localparam int SpiDiv     = 4;
   localparam int ClkNs      = 8;
   localparam int StbClks    = 6;    // Strobe width and gap
   localparam int MaxPolls   = 40;
   localparam logic [31:0] Seed = 32'h4816;
   // Watchdog budget, twice the expected run
   localparam int FrameNs    = 10 * ClksPerBit * ClkNs;
   localparam int SpiNs      = 16 * SpiDiv * ClkNs;
   localparam int AccessNs   = (2 * StbClks + 2) * ClkNs;
   localparam int TimeoutNs  = 2 * (6 * FrameNs + 2 * SpiNs + 100 * AccessNs);

   logic              clk;
   logic              rstN;
   logic              mrN;
   logic              mr;
   logic [NumTty-1:0] ttyTxd;
   logic [NumTty-1:0] ttyRxd;
   logic              sdCdN;
   logic              sdMiso;
   logic              sdMosi;
   logic              sdSclk;
   logic              sdCs;
   logic [7:0]        rpLedsN;
   logic [7:1]        conAddr;
   logic              conBleN;
   logic              conBheN;
   logic              conRdN;
   logic              conWrN;
   logic              conIntrN;
   wire  [15:0]       conData;
   conWordT           conDrv;        // Console side data driver
   logic              conOe;
   logic [31:0]       lfsrState;
   int                errCount    = 0;
   int                checkCount  = 0;
   int                testCount   = 0;
   int                testErrBase = 0;

   assign conData = conOe ? conDrv : 'z;

   `include "tbUtil.svh"

   esmKs10 #(
      .NumTty     (NumTty),
      .ClksPerBit (ClksPerBit),
      .SpiDiv     (SpiDiv)
   ) i_dut (
      .clk50MHz (clk),
      .rstN     (rstN),
      .mrN      (mrN),
      .mr       (mr),
      .ttyTxd   (ttyTxd),
      .ttyRxd   (ttyRxd),
      .sdCdN    (sdCdN),
      .sdMiso   (sdMiso),
      .sdMosi   (sdMosi),
      .sdSclk   (sdSclk),
      .sdCs     (sdCs),
      .rpLedsN  (rpLedsN),
      .conData  (conData),
      .conAddr  (conAddr),
      .conBleN  (conBleN),
      .conBheN  (conBheN),
      .conRdN   (conRdN),
      .conWrN   (conWrN),
      .conIntrN (conIntrN)
   );

   initial begin
      clk = 1'b0;
      forever #(ClkNs / 2) clk = ~clk;
   end

   initial begin
      #(TimeoutNs);
      $display("Watchdog expired at %0t, a test stopped making progress", $time);
      $display("TEST FAILED");
      $finish;
   end

   ////////////////////////////////////////
   // Pin models
   ////////////////////////////////////////

   // Both console lines send at once, 8N1 LSB first
   task automatic sendFrames(input logic [7:0] ch0, input logic [7:0] ch1);
      logic [9:0] f0;
      logic [9:0] f1;
      f0 = {1'b1, ch0, 1'b0};
      f1 = {1'b1, ch1, 1'b0};
      @(negedge clk);
      for (int i = 0; i < 10; i++) begin
         ttyTxd = {f1[i], f0[i]};
         repeat (ClksPerBit) @(negedge clk);
      end
   endtask

   // Find start bit, then sample at mid-bit
   task automatic uartSample(input int line, output logic [7:0] ch);
      int waitCnt;
      waitCnt = 0;
      ch = '0;
      while (ttyRxd[line] !== 1'b0 && waitCnt < 4 * ClksPerBit) begin
         @(negedge clk);
         waitCnt++;
      end
      if (ttyRxd[line] !== 1'b0) begin
         $display("No start bit seen on ttyRxd line %0d", line);
         errCount++;
      end else begin
         repeat (ClksPerBit + ClksPerBit / 2) @(negedge clk);
         for (int i = 0; i < 8; i++) begin
            ch[i] = ttyRxd[line];
            repeat (ClksPerBit) @(negedge clk);
         end
         checkBit("ttyRxd stop bit", ttyRxd[line], 1'b1);
      end
   endtask

   // Mode 0 slave, MISO set up after each falling SCLK
   task automatic spiSlave(input logic [7:0] miso, output logic [7:0] mosi);
      @(negedge clk);
      sdMiso = miso[7];
      for (int i = 7; i >= 0; i--) begin
         @(posedge sdSclk);
         @(negedge clk);
         mosi[i] = sdMosi;   // Stable for the high half
         if (i > 0) begin
            @(negedge sdSclk);
            @(negedge clk);
            sdMiso = miso[i - 1];
         end
      end
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial begin
      conWordT    rd;
      conWordT    wr;
      conWordT    intModel;
      conWordT    ledModel;
      logic [7:0] ch;
      logic [7:0] got;
      logic [7:0] c0;
      logic [7:0] c1;
      logic [7:0] mosiByte;
      logic [7:0] misoByte;
      logic [7:0] capByte;
      logic       pinMoved;
      rstN      = 1'b0;   // Every DUT input idle from time zero
      mrN       = 1'b1;
      ttyTxd    = '1;
      sdCdN     = 1'b0;
      sdMiso    = 1'b1;
      conAddr   = '0;
      conBleN   = 1'b1;
      conBheN   = 1'b1;
      conRdN    = 1'b1;
      conWrN    = 1'b1;
      conDrv    = '0;
      conOe     = 1'b0;
      lfsrState = Seed;
      applyReset();

      // Test 1, every lane combination on both registers
      intModel = '0;
      ledModel = '0;
      for (int l = 0; l < 4; l++) begin
         wr = randBits(16);
         intModel = laneMerge(intModel, wr, 2'(l));
         conWrite(IntMask, wr, 2'(l));
         conRead(IntMask, rd);
         checkWord("IntMask", rd, intModel);
         wr = randBits(16);
         ledModel = laneMerge(ledModel, wr, 2'(l)) & 16'h00ff;   // Only 8 LEDs built
         conWrite(RpLeds, wr, 2'(l));
         conRead(RpLeds, rd);
         checkWord("RpLeds", rd, ledModel);
         checkByte("rpLedsN", rpLedsN, ~ledModel[7:0]);
      end
      conWrite(IntMask, 16'h0000, 2'b11);
      endTest("byte lanes on IntMask and RpLeds");

      // Test 2, transmit on built lines, then an unbuilt one
      for (int line = 0; line < NumTty; line++) begin
         ch = 8'(randBits(8));
         fork
            begin
               conWrite(DzTx, {5'b00000, LineWidth'(line), ch}, 2'b11);
               conRead(DzCsr, rd);
               checkBit("DzCsr tx busy", rd[8 + line], 1'b1);
            end
            uartSample(line, got);
         join
         checkByte("ttyRxd char", got, ch);
         repeat (ClksPerBit) @(negedge clk);   // Rest of stop bit
         conRead(DzCsr, rd);
         checkWord("DzCsr", rd, 16'h0000);
      end
      conWrite(DzTx, {5'b00000, 3'd5, 8'h55}, 2'b11);
      conRead(DzCsr, rd);
      checkWord("DzCsr", rd, 16'h0000);
      pinMoved = 1'b0;
      repeat (10 * ClksPerBit) begin
         @(negedge clk);
         if (ttyRxd !== 2'b11)
            pinMoved = 1'b1;
      end
      checkBit("ttyRxd moved", pinMoved, 1'b0);
      endTest("DZ transmit frames and busy");

      // Test 3, receive on both lines, lowest line pops first
      c0 = 8'(randBits(8));
      c1 = 8'(randBits(8));
      sendFrames(c0, c1);
      waitReg(DzCsr, 16'h00ff, 16'h0003, "Receive valid bits never set on both lines", rd);
      checkBit("conIntrN", conIntrN, intrLevel(1'b1, 1'b0, 16'h0000));
      conWrite(IntMask, 16'h0001, 2'b11);
      checkBit("conIntrN", conIntrN, intrLevel(1'b1, 1'b0, 16'h0001));
      conRead(DzRx, rd);
      checkWord("DzRx", rd, dzRxWord(3'd0, c0));
      conRead(DzCsr, rd);
      checkWord("DzCsr", rd, 16'h0002);
      checkBit("conIntrN", conIntrN, intrLevel(1'b1, 1'b0, 16'h0001));
      conRead(DzRx, rd);
      checkWord("DzRx", rd, dzRxWord(3'd1, c1));
      conRead(DzCsr, rd);
      checkWord("DzCsr", rd, 16'h0000);
      checkBit("conIntrN", conIntrN, intrLevel(1'b0, 1'b0, 16'h0001));
      conRead(DzRx, rd);
      checkBit("DzRx valid", rd[15], 1'b0);
      endTest("DZ receive, pop order and interrupt");

      // Test 4, one SPI byte exchange with done interrupt
      conWrite(IntMask, 16'h0002, 2'b11);
      conWrite(SdCtl, 16'h0001, 2'b01);
      checkBit("sdCs", sdCs, 1'b1);
      conRead(SdCtl, rd);
      checkWord("SdCtl", rd, {13'b0, !sdCdN, 1'b0, 1'b1});
      mosiByte = 8'(randBits(8));
      misoByte = 8'(randBits(8));
      fork
         conWrite(SdData, {8'h00, mosiByte}, 2'b01);
         spiSlave(misoByte, capByte);
      join
      waitReg(SdCtl, 16'h0002, 16'h0000, "SPI busy bit never cleared", rd);
      checkByte("sdMosi byte", capByte, mosiByte);
      conRead(SdData, rd);
      checkWord("SdData", rd, {8'h00, misoByte});
      checkBit("conIntrN", conIntrN, intrLevel(1'b0, 1'b1, 16'h0002));
      conWrite(IntMask, 16'h0002, 2'b11);   // Ack clears the done flag
      checkBit("conIntrN", conIntrN, intrLevel(1'b0, 1'b0, 16'h0002));
      @(negedge clk);
      sdCdN = 1'b1;   // Card pulled
      conRead(SdCtl, rd);
      checkWord("SdCtl", rd, {13'b0, !sdCdN, 1'b0, 1'b1});
      conWrite(SdCtl, 16'h0000, 2'b01);
      checkBit("sdCs", sdCs, 1'b0);
      endTest("SD SPI exchange and card detect");

      // Test 5, master reset pin, then reset values
      for (int i = 0; i < 4; i++) begin
         @(negedge clk);
         mrN = !mrN;
         @(negedge clk);
         checkBit("mr", mr, !mrN);
      end
      conWrite(SdCtl, 16'h0001, 2'b01);   // Something for reset to undo
      applyReset();
      checkBit("conIntrN", conIntrN, 1'b1);
      checkBit("ttyRxd[0]", ttyRxd[0], 1'b1);
      checkBit("ttyRxd[1]", ttyRxd[1], 1'b1);
      checkBit("sdSclk", sdSclk, 1'b0);
      checkBit("sdMosi", sdMosi, 1'b1);
      checkBit("sdCs", sdCs, 1'b0);
      checkByte("rpLedsN", rpLedsN, 8'hff);
      conDrv = 16'h5a3c;   // Released bus reads back our pattern
      conOe  = 1'b1;
      @(negedge clk);
      checkWord("conData", conData, 16'h5a3c);
      conOe  = 1'b0;
      conRead(IntMask, rd);
      checkWord("IntMask", rd, 16'h0000);
      endTest("master reset and reset values");

      $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
      if (errCount == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- verilog/esmKs10.sv
// ESM board top, routes TTY pins, twists TXD/RXD and inverts LEDs, MR and card detect
`timescale 1ns/10ps

module esmKs10 #(
   parameter int NumTty     = 2,
   parameter int ClksPerBit = 434,
   parameter int SpiDiv     = 64
) (
   input  logic              clk50MHz,
   input  logic              rstN,
   input  logic              mrN,       // Master reset button
   output logic              mr,
   input  logic [NumTty-1:0] ttyTxd,    // From FT4232
   output logic [NumTty-1:0] ttyRxd,    // To FT4232
   input  logic              sdCdN,
   input  logic              sdMiso,
   output logic              sdMosi,
   output logic              sdSclk,
   output logic              sdCs,
   output logic [7:0]        rpLedsN,   // Low lights the LED
   inout  wire [15:0]        conData,
   input  logic [7:1]        conAddr,
   input  logic              conBleN,
   input  logic              conBheN,
   input  logic              conRdN,
   input  logic              conWrN,
   output logic              conIntrN
);

   logic [NumTty-1:0] dzRxd;
   logic [NumTty-1:0] dzTxd;
   logic [7:0]        rpLeds;

   conBusIf bus ();

   // Console TXD drives our receivers, so the pair is twisted here
   assign dzRxd   = ttyTxd;
   assign ttyRxd  = dzTxd;
   assign mr      = !mrN;
   assign rpLedsN = ~rpLeds;

   consoleBus i_consoleBus (
      .clk50MHz (clk50MHz),
      .rstN     (rstN),
      .conAddr  (conAddr),
      .conBleN  (conBleN),
      .conBheN  (conBheN),
      .conRdN   (conRdN),
      .conWrN   (conWrN),
      .conData  (conData),
      .bus      (bus.host)
   );

   ks10Io #(
      .NumTty     (NumTty),
      .ClksPerBit (ClksPerBit),
      .SpiDiv     (SpiDiv)
   ) i_ks10Io (
      .clk50MHz (clk50MHz),
      .rstN     (rstN),
      .ttyIn    (dzRxd),
      .ttyOut   (dzTxd),
      .sdCd     (!sdCdN),   // Card detect pin is active low
      .sdMiso   (sdMiso),
      .sdMosi   (sdMosi),
      .sdSclk   (sdSclk),
      .sdCs     (sdCs),
      .leds     (rpLeds),
      .conIntrN (conIntrN),
      .bus      (bus.dev)
   );

endmodule

//--- verilog/ks10Io.sv
// KS10 I/O core, console register decode, interrupts and LEDs around the DZ mux and SD engine
`timescale 1ns/10ps

module ks10Io import ks10Pkg::*; #(
   parameter int NumTty     = 2,
   parameter int ClksPerBit = 434,
   parameter int SpiDiv     = 64
) (
   input  logic              clk50MHz,
   input  logic              rstN,
   input  logic [NumTty-1:0] ttyIn,
   output logic [NumTty-1:0] ttyOut,
   input  logic              sdCd,
   input  logic              sdMiso,
   output logic              sdMosi,
   output logic              sdSclk,
   output logic              sdCs,
   output logic [7:0]        leds,
   output logic              conIntrN,
   conBusIf.dev              bus
);

   conWordT                intMask;
   logic                   spiDoneFlag;   // Sticky until IntMask write
   logic [MaxTty-1:0]      txBusy;
   logic [MaxTty-1:0]      rxValid;
   logic [LineWidth-1:0]   rxLine;
   logic [7:0]             rxChar;
   logic                   rxAny;
   logic                   spiBusy;
   logic                   spiDone;
   logic [7:0]             spiRxByte;
   conWordT                rdMux;

   assign rxAny = |rxValid;

   ////////////////////////////////////////
   // Register writes
   ////////////////////////////////////////

   always_ff @(posedge clk50MHz or negedge rstN) begin
      if (!rstN) begin
         intMask     <= '0;
         leds        <= '0;
         sdCs        <= 1'b0;
         spiDoneFlag <= 1'b0;
      end else begin
         if (bus.wrStb && bus.addr == IntMask) begin
            if (bus.byteEn[0]) begin
               intMask[7:0] <= bus.wrData[7:0];
               spiDoneFlag  <= 1'b0;   // Bit 1 written, ack SPI done
            end
            if (bus.byteEn[1])
               intMask[15:8] <= bus.wrData[15:8];
         end
         if (bus.wrStb && bus.byteEn[0] && bus.addr == RpLeds)
            leds <= bus.wrData[7:0];
         if (bus.wrStb && bus.byteEn[0] && bus.addr == SdCtl)
            sdCs <= bus.wrData[0];
         if (spiDone)
            spiDoneFlag <= 1'b1;
      end
   end

   ////////////////////////////////////////
   // Read mux
   ////////////////////////////////////////

   always_comb begin
      case (bus.addr)
         DzCsr:   rdMux = {txBusy, rxValid};
         DzRx:    rdMux = {rxAny, 4'b0, rxLine, rxChar};
         SdCtl:   rdMux = {13'b0, sdCd, spiBusy, sdCs};
         SdData:  rdMux = {8'b0, spiRxByte};
         IntMask: rdMux = intMask;
         RpLeds:  rdMux = {8'b0, leds};
         default: rdMux = '0;   // DzTx is write only
      endcase
   end

   assign bus.rdData = bus.rdStb ? rdMux : '0;

   // Rx enable on bit 0, SPI done enable on bit 1
   assign conIntrN = !((rxAny && intMask[0]) || (spiDoneFlag && intMask[1]));

   dzMux #(
      .NumTty     (NumTty),
      .ClksPerBit (ClksPerBit)
   ) i_dzMux (
      .clk50MHz (clk50MHz),
      .rstN     (rstN),
      .ttyIn    (ttyIn),
      .ttyOut   (ttyOut),
      .txStart  (bus.wrStb && bus.addr == DzTx),
      .txLine   (bus.wrData[10:8]),
      .txChar   (bus.wrData[7:0]),
      .txBusy   (txBusy),
      .rxValid  (rxValid),
      .rxLine   (rxLine),
      .rxChar   (rxChar),
      .rxPop    (bus.rdDone && bus.addr == DzRx)   // Pop once data is off the bus
   );

   sdSpi #(
      .SpiDiv (SpiDiv)
   ) i_sdSpi (
      .clk50MHz (clk50MHz),
      .rstN     (rstN),
      .start    (bus.wrStb && bus.addr == SdData),
      .txByte   (bus.wrData[7:0]),
      .busy     (spiBusy),
      .rxByte   (spiRxByte),
      .done     (spiDone),
      .sdMiso   (sdMiso),
      .sdMosi   (sdMosi),
      .sdSclk   (sdSclk)
   );

endmodule

//--- verilog/sdSpi.sv
// SD card SPI master, exchanges one byte per start pulse in mode 0, MSB first
`timescale 1ns/10ps

module sdSpi import ks10Pkg::*; #(
   parameter int SpiDiv = 64
) (
   input  logic       clk50MHz,
   input  logic       rstN,
   input  logic       start,
   input  logic [7:0] txByte,
   output logic       busy,
   output logic [7:0] rxByte,
   output logic       done,
   input  logic       sdMiso,
   output logic       sdMosi,
   output logic       sdSclk
);

   localparam int DivWidth = $clog2(SpiDiv + 1);

   spiStateT            state;
   logic [DivWidth-1:0] divCnt;   // Half period counter
   logic [2:0]          bitCnt;
   logic [7:0]          txSh;
   logic                halfTick;

   assign halfTick = divCnt == DivWidth'(SpiDiv - 1);

   ////////////////////////////////////////
   // Control FSM and clock
   ////////////////////////////////////////

   always_ff @(posedge clk50MHz or negedge rstN) begin
      if (!rstN) begin
         state  <= SpiIdle;
         divCnt <= '0;
         bitCnt <= '0;
         sdSclk <= 1'b0;
      end else begin
         case (state)
            SpiIdle: begin
               divCnt <= '0;
               bitCnt <= '0;
               if (start)
                  state <= SpiShift;
            end
            SpiShift: begin
               divCnt <= halfTick ? '0 : divCnt + 1'b1;
               if (halfTick) begin
                  sdSclk <= !sdSclk;
                  if (sdSclk) begin   // Falling edge ends a bit
                     bitCnt <= bitCnt + 1'b1;
                     if (bitCnt == 3'd7)
                        state <= SpiDone;
                  end
               end
            end
            default: state <= SpiIdle;   // One clock of done
         endcase
      end
   end

   ////////////////////////////////////////
   // Shift registers
   ////////////////////////////////////////

   always_ff @(posedge clk50MHz) begin
      if (state == SpiIdle && start)
         txSh <= txByte;
      else if (state == SpiShift && halfTick && sdSclk)
         txSh <= txSh << 1;                 // Next bit on falling edge
      if (state == SpiShift && halfTick && !sdSclk)
         rxByte <= {rxByte[6:0], sdMiso};   // Sample on rising edge
   end

   assign sdMosi = (state == SpiShift) ? txSh[7] : 1'b1;   // Idle high
   assign busy   = state != SpiIdle;
   assign done   = state == SpiDone;

endmodule

//--- verilog/dzMux.sv
// DZ11-style terminal mux, one 8N1 transmitter and receiver per built line
`timescale 1ns/10ps

module dzMux import ks10Pkg::*; #(
   parameter int NumTty     = 2,
   parameter int ClksPerBit = 434
) (
   input  logic                 clk50MHz,
   input  logic                 rstN,
   input  logic [NumTty-1:0]    ttyIn,
   output logic [NumTty-1:0]    ttyOut,
   input  logic                 txStart,
   input  logic [LineWidth-1:0] txLine,
   input  logic [7:0]           txChar,
   output logic [MaxTty-1:0]    txBusy,
   output logic [MaxTty-1:0]    rxValid,   // Valid mask, any bit set means rxLine is live
   output logic [LineWidth-1:0] rxLine,
   output logic [7:0]           rxChar,
   input  logic                 rxPop
);

   localparam int CntWidth = $clog2(ClksPerBit + 1);
   localparam int HalfBit  = ClksPerBit / 2;

   logic [NumTty-1:0]      busyMask;
   logic [NumTty-1:0]      validMask;
   logic [NumTty-1:0][7:0] rxChars;

   for (genvar i = 0; i < NumTty; i++) begin : gLine

      uartStateT           txState;
      logic [CntWidth-1:0] txCnt;
      logic [2:0]          txBit;
      logic [7:0]          txSh;
      logic                txTick;
      uartStateT           rxState;
      logic [CntWidth-1:0] rxCnt;
      logic [2:0]          rxBit;
      logic [7:0]          rxSh;
      logic [7:0]          rxHold;
      logic [1:0]          rxSync;
      logic                rxVal;
      logic                rxTick;
      logic                rxMid;

      ////////////////////////////////////////
      // Transmitter
      ////////////////////////////////////////

      assign txTick = txCnt == CntWidth'(ClksPerBit - 1);

      always_ff @(posedge clk50MHz or negedge rstN) begin
         if (!rstN) begin
            txState <= UartIdle;
            txCnt   <= '0;
            txBit   <= '0;
         end else begin
            txCnt <= txTick ? '0 : txCnt + 1'b1;
            case (txState)
               UartIdle: begin
                  txCnt <= '0;
                  if (txStart && txLine == LineWidth'(i))
                     txState <= UartStart;
               end
               UartStart: if (txTick) txState <= UartData;
               UartData: begin
                  if (txTick) begin
                     txBit <= txBit + 1'b1;
                     if (txBit == 3'd7)
                        txState <= UartStop;   // Eight bits out
                  end
               end
               default: if (txTick) txState <= UartIdle;   // Stop bit
            endcase
         end
      end

      always_ff @(posedge clk50MHz) begin
         if (txState == UartIdle)
            txSh <= txChar;
         else if (txState == UartData && txTick)
            txSh <= txSh >> 1;   // LSB first
      end

      assign ttyOut[i]   = (txState == UartStart) ? 1'b0 :
                           (txState == UartData)  ? txSh[0] : 1'b1;
      assign busyMask[i] = txState != UartIdle;

      ////////////////////////////////////////
      // Receiver
      ////////////////////////////////////////

      assign rxTick = rxCnt == CntWidth'(ClksPerBit - 1);
      assign rxMid  = rxCnt == CntWidth'(HalfBit - 1);

      always_ff @(posedge clk50MHz or negedge rstN) begin
         if (!rstN) begin
            rxSync  <= 2'b11;
            rxState <= UartIdle;
            rxCnt   <= '0;
            rxBit   <= '0;
            rxVal   <= 1'b0;
         end else begin
            rxSync <= {rxSync[0], ttyIn[i]};
            rxCnt  <= rxTick ? '0 : rxCnt + 1'b1;
            if (rxPop && rxLine == LineWidth'(i))
               rxVal <= 1'b0;
            case (rxState)
               UartIdle: begin
                  rxCnt <= '0;
                  if (!rxSync[1])
                     rxState <= UartStart;
               end
               UartStart: begin
                  if (rxMid) begin   // Recheck start at mid-bit
                     rxCnt   <= '0;
                     rxBit   <= '0;
                     rxState <= rxSync[1] ? UartIdle : UartData;
                  end
               end
               UartData: begin
                  if (rxTick) begin
                     rxBit <= rxBit + 1'b1;
                     if (rxBit == 3'd7)
                        rxState <= UartStop;
                  end
               end
               default: begin
                  if (rxTick) begin
                     rxState <= UartIdle;
                     if (rxSync[1])
                        rxVal <= 1'b1;   // Good stop bit, overwrite wins
                  end
               end
            endcase
         end
      end

      always_ff @(posedge clk50MHz) begin
         if (rxState == UartData && rxTick)
            rxSh <= {rxSync[1], rxSh[7:1]};
         if (rxState == UartStop && rxTick && rxSync[1])
            rxHold <= rxSh;
      end

      assign validMask[i] = rxVal;
      assign rxChars[i]   = rxHold;

   end

   assign txBusy  = MaxTty'(busyMask);    // Unbuilt lines read idle
   assign rxValid = MaxTty'(validMask);

   // Lowest valid line wins
   always_comb begin
      rxLine = '0;
      rxChar = '0;
      for (int i = NumTty - 1; i >= 0; i--) begin
         if (validMask[i]) begin
            rxLine = LineWidth'(i);
            rxChar = rxChars[i];
         end
      end
   end

endmodule

//--- verilog/consoleBus.sv
// Console bus front end, syncs async strobes and drives conData during reads
`timescale 1ns/10ps

module consoleBus import ks10Pkg::*; (
   input  logic       clk50MHz,
   input  logic       rstN,
   input  logic [7:1] conAddr,
   input  logic       conBleN,
   input  logic       conBheN,
   input  logic       conRdN,
   input  logic       conWrN,
   inout  wire [15:0] conData,
   conBusIf.host      bus
);

   busStateT   state;
   logic [1:0] wrSync;   // Write strobe sync chain
   logic [1:0] rdSync;   // Read strobe sync chain
   logic       wrLow;
   logic       rdLow;

   ////////////////////////////////////////
   // Strobe synchronizers
   ////////////////////////////////////////

   always_ff @(posedge clk50MHz or negedge rstN) begin
      if (!rstN) begin
         wrSync <= 2'b11;   // Strobes idle high
         rdSync <= 2'b11;
      end else begin
         wrSync <= {wrSync[0], conWrN};
         rdSync <= {rdSync[0], conRdN};
      end
   end

   assign wrLow = !wrSync[1];
   assign rdLow = !rdSync[1];

   ////////////////////////////////////////
   // Access FSM
   ////////////////////////////////////////

   always_ff @(posedge clk50MHz or negedge rstN) begin
      if (!rstN) begin
         state <= BusIdle;
      end else begin
         case (state)
            BusIdle: begin
               if (wrLow)
                  state <= BusWrite;
               else if (rdLow)
                  state <= BusRead;
            end
            BusWrite: if (!wrLow) state <= BusIdle;   // Wait for strobe release
            BusRead:  if (!rdLow) state <= BusIdle;
            default:  state <= BusIdle;
         endcase
      end
   end

   // Address, data and lanes follow the pins until an access starts
   always_ff @(posedge clk50MHz) begin
      if (state == BusIdle) begin
         bus.addr   <= regAddrT'(conAddr);
         bus.wrData <= conData;
         bus.byteEn <= {!conBheN, !conBleN};
      end
   end

   assign bus.wrStb  = (state == BusIdle) && wrLow;   // Falling edge of synced strobe
   assign bus.rdStb  = (state == BusRead && rdLow) ||
                       (state == BusIdle && rdLow && !wrLow);
   assign bus.rdDone = (state == BusRead) && !rdLow;  // Data already off the bus

   // Tristate driver
   assign conData = bus.rdStb ? bus.rdData : 'z;

endmodule

//--- verilog/conBusIf.sv
// Decoded console register access between the bus front end and the I/O core
`timescale 1ns/10ps

interface conBusIf import ks10Pkg::*; ();

   regAddrT addr;          // Latched word address
   conWordT wrData;        // Latched write data
   logic    [1:0] byteEn;  // [1] high lane, [0] low lane
   logic    wrStb;         // One clock per write
   logic    rdStb;         // Level while read active
   logic    rdDone;        // One clock as read ends
   conWordT rdData;        // Register read mux

   // Front end side
   modport host (output addr, wrData, byteEn, wrStb, rdStb, rdDone,
                 input  rdData);

   // Register side
   modport dev  (input  addr, wrData, byteEn, wrStb, rdStb, rdDone,
                 output rdData);

endinterface

//--- verilog/ks10Pkg.sv
// Register map, state encodings and bus widths shared by the KS10 I/O RTL and its testbench
package ks10Pkg;

   ////////////////////////////////////////
   // Bus widths
   ////////////////////////////////////////

   localparam int ConDataWidth = 16;   // Console data bus
   localparam int ConAddrWidth = 7;    // Word address from conAddr[7:1]
   localparam int MaxTty       = 8;    // Lines the DZ line field can reach
   localparam int LineWidth    = 3;    // DZ line select field

   typedef logic [ConDataWidth-1:0] conWordT;

   ////////////////////////////////////////
   // Console register word addresses
   ////////////////////////////////////////

   typedef enum logic [ConAddrWidth-1:0] {
      DzCsr   = 7'd0,   // RO, [15:8] tx busy, [7:0] rx valid
      DzTx    = 7'd1,   // WO, [10:8] line, [7:0] char
      DzRx    = 7'd2,   // RO, [15] valid, [10:8] line, [7:0] char
      SdCtl   = 7'd3,   // [0] CS, [1] busy (RO), [2] card detect (RO)
      SdData  = 7'd4,   // Write starts exchange, read gives last byte
      IntMask = 7'd5,   // [0] rx enable, [1] SPI done enable
      RpLeds  = 7'd6    // Activity LEDs
   } regAddrT;

   ////////////////////////////////////////
   // State machine encodings
   ////////////////////////////////////////

   // UART tx and rx
   typedef enum logic [1:0] {
      UartIdle,
      UartStart,
      UartData,
      UartStop
   } uartStateT;

   // SPI byte engine
   typedef enum logic [1:0] {
      SpiIdle,
      SpiShift,
      SpiDone
   } spiStateT;

   // Console bus front end
   typedef enum logic [1:0] {
      BusIdle,
      BusWrite,
      BusRead
   } busStateT;

endpackage
